/* hdl/besm_pkg.sv */
`default_nettype none

package besm_pkg;

    // --------------------
    // Microinstruction field codes
    typedef enum logic [3:0] {
        YD_NONE   = 4'd0,
        YD_MODGN  = 4'd1,     // Modifier group number
        YD_PROCN  = 4'd2,     // Process number
        YD_RR     = 4'd3,     // Mode register
        YD_PHYSPG = 4'd4,     // Physical page
        YD_ARB    = 4'd5,     // Arbiter request code
        YD_WDATA  = 4'd6,     // Bus write data
        YD_UREG   = 4'd8      // Executive address
    } ydst_t;

    typedef enum logic [2:0] {
        YV_NONE  = 3'd0,
        YV_UREG  = 3'd3,      // Executive address read
        YV_PSMEM = 3'd4,      // Page-assignment memory
        YV_MPMEM = 3'd5       // Console exchange memory
    } ydev_t;

    typedef enum logic [3:0] {
        DS_NONE   = 4'd0,
        DS_MODGN  = 4'd1,
        DS_PROCN  = 4'd2,
        DS_RR     = 4'd3,
        DS_PHYSPG = 4'd4,
        DS_ARB    = 4'd5,
        DS_RDATA  = 4'd6      // Captured bus read data
    } dsrc_t;

    typedef enum logic [4:0] {
        LOGGRP = 5'd1, MULGRP = 5'd2, ADDGRP = 5'd3, SETC = 5'd5,
        CLRRCB = 5'd6, SETRCB = 5'd7, CLRJMP = 5'd8, SETJMP = 5'd9,
        SETEI  = 5'd10, CLREI = 5'd11, CLRTR0 = 5'd12, SETTR0 = 5'd13,
        CLRTR1 = 5'd14, SETTR1 = 5'd15, CLRTKK = 5'd18, SETTKK = 5'd19,
        SETNR  = 5'd20, SETER = 5'd22, CHTKK = 5'd23
    } ffcnt_t;

    typedef enum logic [4:0] {
        YES = 5'd0, NORMB = 5'd1, RNDB = 5'd2, OVRIB = 5'd3, BNB = 5'd4,
        OVRFTB = 5'd5, DRG = 5'd6, EMLRG = 5'd7, RCB = 5'd8, CB = 5'd9,
        CEMLRG = 5'd10, TR1 = 5'd12, INTSTP = 5'd13, TKK = 5'd15,
        ARBRDY = 5'd21, TR0 = 5'd22
    } cond_t;

    // --------------------
    // External bus arbiter
    typedef enum logic [3:0] {ARB_IDLE = 4'd0, ARB_READ = 4'd1, ARB_WRITE = 4'd2} arb_op_t;
    typedef enum logic [1:0] {ST_IDLE, ST_ADDR, ST_DATA} arb_state_t;

endpackage

`default_nettype wire

/* hdl/flag_unit.sv */
`default_nettype none
`timescale 1ns/1ps

module flag_unit
    import besm_pkg::*;
#(
    parameter int WORD_W = 64
) (
    input  wire               clk,
    input  wire               reset,
    input  wire  [WORD_W-1:0] i_y,          // Y bus
    input  wire  ydst_t       i_ydst,       // Y destination
    input  wire               i_iomp,       // Low selects the flip-flop decoder
    input  wire  ffcnt_t      i_ffcnt,      // Set/reset code
    input  wire               i_ise,        // Copy tkk into rcb
    input  wire  cond_t       i_cond,       // Condition select
    input  wire               i_icc,        // High passes condition, low inverts
    input  wire               i_arb_rdy,    // Arbiter ready pulse
    output logic [31:0]       o_rr,         // Mode register
    output logic              o_cond        // Polarized condition
);

    // Mode register bit positions
    localparam int RR_NORMB  = 0;           // Normalization block
    localparam int RR_RNDB   = 1;           // Rounding block
    localparam int RR_GRP    = 2;           // Condition group, 3 bits
    localparam int RR_OVRIB  = 5;           // Overflow interrupt block
    localparam int RR_BNB    = 10;          // Range check block
    localparam int RR_OVRFTB = 11;
    localparam int RR_DRG    = 12;          // Dispatcher mode
    localparam int RR_NOINTR = 17;          // External interrupt mask
    localparam int RR_CEMLRG = 19;
    localparam int RR_INTSTP = 21;          // Stop on interrupt
    localparam int RR_CB     = 27;          // Address changed by index 16
    localparam int RR_RCB    = 28;          // Right half-word flag
    localparam int RR_JUMP   = 29;          // Control transfer flag

    logic [31:0] rr;                        // Mode register
    logic        tr0;                       // Microprogram flag 0
    logic        tr1;                       // Microprogram flag 1
    logic        tkk;                       // Standardizer right-command flag
    logic        emlrg;                     // Emulation mode
    logic        cond_src;                  // Selected condition before polarity

    // --------------------
    // Register load and flag codes
    always_ff @(posedge clk) begin
        if (reset) begin
            rr    <= '0;
            tr0   <= 1'b0;
            tr1   <= 1'b0;
            tkk   <= 1'b0;
            emlrg <= 1'b0;
        end else begin
            if (i_ydst == YD_RR)
                rr <= i_y[31:0];                        // Full load from Y
            if (!i_iomp) begin                          // Later writes override the load
                case (i_ffcnt)
                    LOGGRP: rr[RR_GRP +: 3] <= 3'b001;  // Logic group
                    MULGRP: rr[RR_GRP +: 3] <= 3'b010;  // Multiply group
                    ADDGRP: rr[RR_GRP +: 3] <= 3'b100;  // Add group
                    SETC:   rr[RR_CB]       <= 1'b1;
                    CLRRCB: rr[RR_RCB]      <= 1'b0;
                    SETRCB: rr[RR_RCB]      <= 1'b1;
                    CLRJMP: rr[RR_JUMP]     <= 1'b0;
                    SETJMP: rr[RR_JUMP]     <= 1'b1;
                    SETEI:  rr[RR_NOINTR]   <= 1'b0;    // Enable interrupts
                    CLREI:  rr[RR_NOINTR]   <= 1'b1;    // Mask interrupts
                    CLRTR0: tr0             <= 1'b0;
                    SETTR0: tr0             <= 1'b1;
                    CLRTR1: tr1             <= 1'b0;
                    SETTR1: tr1             <= 1'b1;
                    CLRTKK: tkk             <= 1'b0;
                    SETTKK: tkk             <= 1'b1;
                    SETNR:  emlrg           <= 1'b0;    // Native mode
                    SETER:  emlrg           <= 1'b1;    // Emulation mode
                    CHTKK:  tkk             <= ~tkk;    // Toggle
                    default: ;
                endcase
            end
            if (i_ise)
                rr[RR_RCB] <= tkk;                      // Beats rcb set/reset codes
        end
    end

    assign o_rr = rr;

    // --------------------
    // Condition multiplexer
    always_comb begin
        case (i_cond)
            NORMB:   cond_src = rr[RR_NORMB];
            RNDB:    cond_src = rr[RR_RNDB];
            OVRIB:   cond_src = rr[RR_OVRIB];
            BNB:     cond_src = rr[RR_BNB];
            OVRFTB:  cond_src = rr[RR_OVRFTB];
            DRG:     cond_src = rr[RR_DRG];
            EMLRG:   cond_src = emlrg;
            RCB:     cond_src = rr[RR_RCB];
            CB:      cond_src = rr[RR_CB];
            CEMLRG:  cond_src = rr[RR_CEMLRG];
            TR1:     cond_src = tr1;
            INTSTP:  cond_src = rr[RR_INTSTP];
            TKK:     cond_src = tkk;
            ARBRDY:  cond_src = i_arb_rdy;
            TR0:     cond_src = tr0;
            default: cond_src = 1'b1;                   // YES and absent sources
        endcase
    end

    assign o_cond = i_icc ? cond_src : ~cond_src;

endmodule

`default_nettype wire

/* hdl/special_regs.sv */
`default_nettype none
`timescale 1ns/1ps

module special_regs
    import besm_pkg::*;
#(
    parameter int WORD_W    = 64,
    parameter int PAGE_BITS = 10,
    parameter int MP_BITS   = 4
) (
    input  wire                clk,
    input  wire                reset,
    input  wire  [WORD_W-1:0]  i_y,           // Y bus
    input  wire  ydst_t        i_ydst,        // Y destination
    input  wire  ydev_t        i_ydev,        // Y device
    input  wire                i_wry,         // Device write
    input  wire  [MP_BITS-1:0] i_mpadr,       // Exchange memory address
    output logic [4:0]         o_modgn,
    output logic [7:0]         o_procn,
    output logic [9:0]         o_physpg,
    output logic [31:0]        o_ureg,
    output logic [WORD_W-1:0]  o_wdata,
    output logic [19:0]        o_psmem_rd,    // Page-assignment word at UREG page
    output logic [7:0]         o_mpmem_rd     // Exchange word at i_mpadr
);

    logic [4:0]           modgn;            // Modifier group number
    logic [7:0]           procn;            // Process number
    logic [9:0]           physpg;           // Physical page
    logic [31:0]          ureg;             // Executive address
    logic [WORD_W-1:0]    wdata;            // Bus write data
    logic [PAGE_BITS-1:0] ps_idx;           // Page index from UREG

    logic [19:0] psmem [1 << PAGE_BITS];    // Page-assignment memory
    logic [7:0]  mpmem [1 << MP_BITS];      // Console exchange memory

    // --------------------
    // Y-bus destination registers
    always_ff @(posedge clk) begin
        if (reset) begin
            modgn  <= '0;
            procn  <= '0;
            physpg <= '0;
            ureg   <= '0;
            wdata  <= '0;
        end else begin
            case (i_ydst)
                YD_MODGN:  modgn  <= i_y[9:5];
                YD_PROCN:  procn  <= i_y[7:0];
                YD_PHYSPG: physpg <= i_y[20:11];
                YD_UREG:   ureg   <= i_y[31:0];
                YD_WDATA:  wdata  <= i_y;       // Full word
                default: ;
            endcase
        end
    end

    // --------------------
    // Small memories
    assign ps_idx = ureg[PAGE_BITS+9:10];

    always_ff @(posedge clk) begin
        if (i_wry) begin
            case (i_ydev)
                YV_PSMEM: psmem[ps_idx]  <= i_y[19:0];
                YV_MPMEM: mpmem[i_mpadr] <= i_y[7:0];
                default: ;
            endcase
        end
    end

    assign o_psmem_rd = psmem[ps_idx];      // Asynchronous reads
    assign o_mpmem_rd = mpmem[i_mpadr];

    assign o_modgn  = modgn;
    assign o_procn  = procn;
    assign o_physpg = physpg;
    assign o_ureg   = ureg;
    assign o_wdata  = wdata;

endmodule

`default_nettype wire

/* hdl/bus_arbiter.sv */
`default_nettype none
`timescale 1ns/1ps

module bus_arbiter
    import besm_pkg::*;
#(
    parameter int WORD_W = 64
) (
    input  wire               clk,
    input  wire               reset,
    input  wire  [WORD_W-1:0] i_y,          // Y bus
    input  wire  ydst_t       i_ydst,       // Y destination
    input  wire  arb_op_t     i_arbi,       // Request from microinstruction
    input  wire  [31:0]       i_ureg,       // Address source
    input  wire  [WORD_W-1:0] i_wdata,      // Write data source
    input  wire  [WORD_W-1:0] i_data,       // External read data
    output arb_op_t           o_req,        // Request register
    output logic              o_rdy,        // Ready pulse in data phase
    output logic [WORD_W-1:0] o_rdata,      // Captured read data
    output logic [WORD_W-1:0] o_ad,         // Address or write data
    output logic              o_astb,       // Address strobe
    output logic              o_rd,         // Read strobe
    output logic              o_wr          // Write strobe
);

    arb_state_t        state;
    arb_op_t           req;
    logic [WORD_W-1:0] rdata;

    // --------------------
    // Request register and sequencer
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_IDLE;
            req   <= ARB_IDLE;
            rdata <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (req != ARB_IDLE)
                        state <= ST_ADDR;               // Start bus cycle
                    else if (i_ydst == YD_ARB)
                        req <= arb_op_t'(i_y[3:0]);     // Request from Y bus
                    else if (i_arbi != ARB_IDLE)
                        req <= i_arbi;                  // Request from field
                end
                ST_ADDR: state <= ST_DATA;
                ST_DATA: begin
                    if (req == ARB_READ)
                        rdata <= i_data;                // Capture at end of data phase
                    req   <= ARB_IDLE;
                    state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Strobes decoded from state
    always_comb begin
        o_astb = (state == ST_ADDR);
        o_rdy  = (state == ST_DATA);
        o_rd   = (state == ST_DATA) && (req == ARB_READ);
        o_wr   = (state == ST_DATA) && (req == ARB_WRITE);
        o_ad   = '0;
        if (state == ST_ADDR)
            o_ad = WORD_W'(i_ureg);                     // Address phase
        else if (state == ST_DATA && req == ARB_WRITE)
            o_ad = i_wdata;                             // Write data phase
    end

    assign o_req   = req;
    assign o_rdata = rdata;

endmodule

`default_nettype wire

/* hdl/cpu_ctrl.sv */
`default_nettype none
`timescale 1ns/1ps

module cpu_ctrl
    import besm_pkg::*;
#(
    parameter int WORD_W    = 64,
    parameter int PAGE_BITS = 10,
    parameter int MP_BITS   = 4
) (
    input  wire                clk,
    input  wire                reset,
    input  wire  ydst_t        i_ydst,      // Y destination field
    input  wire  ydev_t        i_ydev,      // Y device field
    input  wire                i_wry,       // Device write
    input  wire                i_alu_en,    // ALU drives Y
    input  wire  [WORD_W-1:0]  i_alu_y,     // ALU result
    input  wire  dsrc_t        i_dsrc,      // D source field
    input  wire  [MP_BITS-1:0] i_mpadr,     // Exchange memory address
    input  wire                i_iomp,
    input  wire  ffcnt_t       i_ffcnt,     // Flip-flop code
    input  wire                i_ise,
    input  wire  cond_t        i_cond,      // Condition select
    input  wire                i_icc,       // Condition polarity
    input  wire  arb_op_t      i_arbi,      // Arbiter request field
    input  wire  [WORD_W-1:0]  i_data,      // External bus data in
    output logic [WORD_W-1:0]  o_y,
    output logic [WORD_W-1:0]  o_d,
    output logic               o_cond,
    output logic [WORD_W-1:0]  o_ad,
    output logic               o_astb,
    output logic               o_rd,
    output logic               o_wr
);

    logic [WORD_W-1:0] y_bus;
    logic [WORD_W-1:0] d_bus;
    logic [4:0]        modgn;
    logic [7:0]        procn;
    logic [9:0]        physpg;
    logic [31:0]       ureg;
    logic [WORD_W-1:0] wdata;
    logic [19:0]       psmem_rd;
    logic [7:0]        mpmem_rd;
    logic [31:0]       rr;
    arb_op_t           arb_req;
    logic              arb_rdy;
    logic [WORD_W-1:0] rdata;

    // --------------------
    // Y bus, first match wins
    always_comb begin
        if (i_ydev == YV_UREG && !i_wry)
            y_bus = WORD_W'(ureg);
        else if (i_ydev == YV_PSMEM && !i_wry)
            y_bus = WORD_W'(psmem_rd);              // Beats ALU
        else if (i_ydev == YV_MPMEM && !i_wry)
            y_bus = WORD_W'(mpmem_rd);
        else if (i_alu_en)
            y_bus = i_alu_y;
        else
            y_bus = '0;
    end

    // D bus source select
    always_comb begin
        case (i_dsrc)
            DS_MODGN:  d_bus = WORD_W'({modgn, 5'd0});
            DS_PROCN:  d_bus = WORD_W'(procn);
            DS_RR:     d_bus = WORD_W'(rr);
            DS_PHYSPG: d_bus = WORD_W'({physpg, 11'd0});
            DS_ARB:    d_bus = WORD_W'(arb_req);
            DS_RDATA:  d_bus = rdata;
            default:   d_bus = '0;
        endcase
    end

    assign o_y = y_bus;
    assign o_d = d_bus;

    // --------------------
    special_regs #(.WORD_W(WORD_W), .PAGE_BITS(PAGE_BITS), .MP_BITS(MP_BITS)) special_regs_i (
        .clk(clk), .reset(reset), .i_y(y_bus), .i_ydst(i_ydst), .i_ydev(i_ydev),
        .i_wry(i_wry), .i_mpadr(i_mpadr), .o_modgn(modgn), .o_procn(procn),
        .o_physpg(physpg), .o_ureg(ureg), .o_wdata(wdata), .o_psmem_rd(psmem_rd),
        .o_mpmem_rd(mpmem_rd)
    );

    flag_unit #(.WORD_W(WORD_W)) flag_unit_i (
        .clk(clk), .reset(reset), .i_y(y_bus), .i_ydst(i_ydst), .i_iomp(i_iomp),
        .i_ffcnt(i_ffcnt), .i_ise(i_ise), .i_cond(i_cond), .i_icc(i_icc),
        .i_arb_rdy(arb_rdy), .o_rr(rr), .o_cond(o_cond)
    );

    bus_arbiter #(.WORD_W(WORD_W)) bus_arbiter_i (
        .clk(clk), .reset(reset), .i_y(y_bus), .i_ydst(i_ydst), .i_arbi(i_arbi),
        .i_ureg(ureg), .i_wdata(wdata), .i_data(i_data), .o_req(arb_req),
        .o_rdy(arb_rdy), .o_rdata(rdata), .o_ad(o_ad), .o_astb(o_astb),
        .o_rd(o_rd), .o_wr(o_wr)
    );

endmodule

`default_nettype wire

/* tb/tb_clock.sv */
`default_nettype none
`timescale 1ns/1ps

module tb_clock #(
    parameter int HALF_PERIOD  = 5,         // 10 ns clock
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        reset = 1'b1;                       // Held from time 0
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;                      // Released after third edge
    end

endmodule

`default_nettype wire

/* tb/cpu_ctrl_assert.sv */
`default_nettype none
`timescale 1ns/1ps

module cpu_ctrl_assert (
    input wire clk,
    input wire reset,
    input wire i_astb,
    input wire i_rd,
    input wire i_wr
);

    // --------------------
    // External bus strobe rules
    a_rd_wr_excl: assert property (@(posedge clk) disable iff (reset) !(i_rd && i_wr))
        else $error("Read and write strobes high in the same cycle");

    a_data_after_addr: assert property (@(posedge clk) disable iff (reset)
        i_astb |=> (i_rd || i_wr))          // Data phase right after address
        else $error("No read or write strobe after the address strobe");

    a_addr_before_data: assert property (@(posedge clk) disable iff (reset)
        (i_rd || i_wr) |-> $past(i_astb))
        else $error("Read or write strobe without an address strobe before it");

    a_astb_single: assert property (@(posedge clk) disable iff (reset) i_astb |=> !i_astb)
        else $error("Address strobe high on two cycles in a row");

endmodule

`default_nettype wire

/* tb/cpu_ctrl_tb.sv */
`default_nettype none
`timescale 1ns/1ps

module cpu_ctrl_tb
    import besm_pkg::*;
();

    localparam int WORD_W    = 64;
    localparam int PAGE_BITS = 10;
    localparam int MP_BITS   = 4;
    localparam int PHASE_LEN = 400;                     // Cycles per test phase
    localparam int N_PHASES  = 5;
    localparam int TIMEOUT   = PHASE_LEN * N_PHASES + 50;

    wire               clk;
    wire               reset;
    ydst_t             i_ydst;
    ydev_t             i_ydev;
    logic              i_wry;
    logic              i_alu_en;
    logic [WORD_W-1:0] i_alu_y;
    dsrc_t             i_dsrc;
    logic [MP_BITS-1:0] i_mpadr;
    logic              i_iomp;
    ffcnt_t            i_ffcnt;
    logic              i_ise;
    cond_t             i_cond;
    logic              i_icc;
    arb_op_t           i_arbi;
    logic [WORD_W-1:0] i_data;
    wire  [WORD_W-1:0] o_y;
    wire  [WORD_W-1:0] o_d;
    wire  [WORD_W-1:0] o_ad;
    wire               o_cond;
    wire               o_astb;
    wire               o_rd;
    wire               o_wr;

    // Reference model state
    logic [4:0]  m_modgn;
    logic [7:0]  m_procn;
    logic [9:0]  m_physpg;
    logic [31:0] m_ureg;
    logic [63:0] m_wdata;
    logic [63:0] m_rdata;                               // Captured read data
    logic [31:0] m_rr;                                  // Mode register
    logic        m_tr0;
    logic        m_tr1;
    logic        m_tkk;
    logic        m_eml;                                 // Emulation mode
    logic [3:0]  m_req;                                 // Arbiter request
    arb_state_t  m_st;
    logic [19:0] m_ps [1 << PAGE_BITS];
    logic        ps_ok [1 << PAGE_BITS];                // Entry written
    logic [7:0]  m_mp [1 << MP_BITS];
    logic        mp_ok [1 << MP_BITS];
    ydst_t       last_dst;
    int          seed = 73;
    int          cycles = 0;

    tb_clock tb_clock_i (.clk(clk), .reset(reset));

    cpu_ctrl #(.WORD_W(WORD_W), .PAGE_BITS(PAGE_BITS), .MP_BITS(MP_BITS)) cpu_ctrl_i (
        .clk(clk), .reset(reset), .i_ydst(i_ydst), .i_ydev(i_ydev), .i_wry(i_wry),
        .i_alu_en(i_alu_en), .i_alu_y(i_alu_y), .i_dsrc(i_dsrc), .i_mpadr(i_mpadr),
        .i_iomp(i_iomp), .i_ffcnt(i_ffcnt), .i_ise(i_ise), .i_cond(i_cond), .i_icc(i_icc),
        .i_arbi(i_arbi), .i_data(i_data), .o_y(o_y), .o_d(o_d), .o_cond(o_cond),
        .o_ad(o_ad), .o_astb(o_astb), .o_rd(o_rd), .o_wr(o_wr)
    );

    bind bus_arbiter cpu_ctrl_assert cpu_ctrl_assert_i (
        .clk(clk), .reset(reset), .i_astb(o_astb), .i_rd(o_rd), .i_wr(o_wr)
    );

    function automatic logic [31:0] next_random();
        return $random(seed);
    endfunction

    task automatic compare(input string name, input logic [63:0] exp_v, input logic [63:0] act_v);
        if (exp_v !== act_v) begin
            $display("Error at %0t ns: %s expected %h, got %h", $time, name, exp_v, act_v);
            $display("Done: errors found");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    // --------------------
    // Model of the Y bus, D bus and condition
    function automatic logic [63:0] model_y();
        if (!i_wry && i_ydev == YV_UREG)
            return {32'd0, m_ureg};
        if (!i_wry && i_ydev == YV_PSMEM)
            return {44'd0, m_ps[m_ureg[19:10]]};        // Memory beats ALU
        if (!i_wry && i_ydev == YV_MPMEM)
            return {56'd0, m_mp[i_mpadr]};
        return i_alu_en ? i_alu_y : 64'd0;
    endfunction

    function automatic logic [63:0] model_d();
        case (i_dsrc)
            DS_MODGN:  return {54'd0, m_modgn, 5'd0};
            DS_PROCN:  return {56'd0, m_procn};
            DS_RR:     return {32'd0, m_rr};
            DS_PHYSPG: return {43'd0, m_physpg, 11'd0};
            DS_ARB:    return {60'd0, m_req};
            DS_RDATA:  return m_rdata;
            default:   return 64'd0;
        endcase
    endfunction

    function automatic logic model_cond();
        logic src;
        case (i_cond)
            NORMB:   src = m_rr[0];
            RNDB:    src = m_rr[1];
            OVRIB:   src = m_rr[5];
            BNB:     src = m_rr[10];
            OVRFTB:  src = m_rr[11];
            DRG:     src = m_rr[12];
            EMLRG:   src = m_eml;
            RCB:     src = m_rr[28];
            CB:      src = m_rr[27];
            CEMLRG:  src = m_rr[19];
            TR1:     src = m_tr1;
            INTSTP:  src = m_rr[21];
            TKK:     src = m_tkk;
            ARBRDY:  src = (m_st == ST_DATA);           // Ready pulse
            TR0:     src = m_tr0;
            default: src = 1'b1;                        // No source here
        endcase
        return i_icc ? src : !src;
    endfunction

    // Clock edge update, from the inputs of the ending cycle
    task automatic advance_model();
        logic [63:0] y;
        logic        old_tkk;
        y = model_y();
        old_tkk = m_tkk;
        if (i_wry && i_ydev == YV_PSMEM) begin          // Index from UREG before any load
            m_ps[m_ureg[19:10]] = y[19:0];
            ps_ok[m_ureg[19:10]] = 1'b1;
        end
        if (i_wry && i_ydev == YV_MPMEM) begin
            m_mp[i_mpadr] = y[7:0];
            mp_ok[i_mpadr] = 1'b1;
        end
        case (i_ydst)
            YD_MODGN:  m_modgn = y[9:5];
            YD_PROCN:  m_procn = y[7:0];
            YD_RR:     m_rr = y[31:0];
            YD_PHYSPG: m_physpg = y[20:11];
            YD_UREG:   m_ureg = y[31:0];
            YD_WDATA:  m_wdata = y;
            default: ;
        endcase
        if (!i_iomp) begin                              // Flag code wins over RR load
            case (i_ffcnt)
                LOGGRP: m_rr[4:2] = 3'b001;
                MULGRP: m_rr[4:2] = 3'b010;
                ADDGRP: m_rr[4:2] = 3'b100;
                SETC:   m_rr[27] = 1'b1;
                CLRRCB: m_rr[28] = 1'b0;
                SETRCB: m_rr[28] = 1'b1;
                CLRJMP: m_rr[29] = 1'b0;
                SETJMP: m_rr[29] = 1'b1;
                SETEI:  m_rr[17] = 1'b0;                // Interrupt mask off
                CLREI:  m_rr[17] = 1'b1;
                CLRTR0: m_tr0 = 1'b0;
                SETTR0: m_tr0 = 1'b1;
                CLRTR1: m_tr1 = 1'b0;
                SETTR1: m_tr1 = 1'b1;
                CLRTKK: m_tkk = 1'b0;
                SETTKK: m_tkk = 1'b1;
                SETNR:  m_eml = 1'b0;
                SETER:  m_eml = 1'b1;
                CHTKK:  m_tkk = !old_tkk;
                default: ;
            endcase
        end
        if (i_ise)
            m_rr[28] = old_tkk;                         // Beats rcb codes
        case (m_st)
            ST_IDLE: begin
                if (m_req != 4'd0)
                    m_st = ST_ADDR;
                else if (i_ydst == YD_ARB)
                    m_req = y[3:0];
                else if (i_arbi != ARB_IDLE)
                    m_req = i_arbi;
            end
            ST_ADDR: m_st = ST_DATA;
            default: begin                              // End of data phase
                if (m_req == 4'd1)
                    m_rdata = i_data;
                m_req = 4'd0;
                m_st = ST_IDLE;
            end
        endcase
    endtask

    // --------------------
    // Random stimulus, biased per phase
    task automatic drive_random(input int phase);
        logic [31:0] r;
        logic [31:0] r2;
        logic [63:0] alu;
        ydst_t       dst;
        ydev_t       dev;
        dsrc_t       src;
        logic        wry;
        logic        en;
        logic [3:0]  mp;
        r = next_random();
        r2 = next_random();
        alu = {next_random(), next_random()};
        if (phase != 1)
            alu[19:13] = 7'd0;                          // Few pages, so reads hit writes
        case (r[1:0])
            2'd0: dev = YV_NONE;
            2'd1: dev = YV_UREG;
            2'd2: dev = YV_PSMEM;
            default: dev = YV_MPMEM;
        endcase
        wry = r[2];
        mp = r[6:3];
        en = (phase == 2) ? 1'b1 : r[15];
        src = dsrc_t'({1'b0, r[14:12]});
        case (phase)
            1: begin
                case (r[10:8])
                    3'd0: dst = YD_MODGN;
                    3'd1: dst = YD_PROCN;
                    3'd2: dst = YD_RR;
                    3'd3: dst = YD_PHYSPG;
                    3'd4: dst = YD_WDATA;
                    3'd5: dst = YD_UREG;
                    default: dst = YD_NONE;
                endcase
                if (last_dst >= YD_MODGN && last_dst <= YD_PHYSPG)
                    src = dsrc_t'(last_dst);            // Read back last load
            end
            2: dst = (r[9:8] == 2'd0) ? YD_UREG : YD_NONE;
            3, 4: begin
                dst = (r[9:8] == 2'd0) ? YD_RR : YD_NONE;
                if (phase == 3)
                    src = DS_RR;
            end
            default: begin
                dst = (r[9:8] == 2'd0) ? YD_ARB : ((r[9:8] == 2'd1) ? YD_UREG : YD_WDATA);
                src = r[12] ? DS_RDATA : DS_ARB;
            end
        endcase
        if (dst == YD_ARB) begin                        // Read or write code on Y
            dev = YV_NONE;
            en = 1'b1;
            alu[3:0] = r[11] ? 4'd1 : 4'd2;
        end
        if (!wry && dev == YV_PSMEM && !ps_ok[m_ureg[19:10]])
            wry = 1'b1;                                 // Unwritten entry, write it
        if (!wry && dev == YV_MPMEM && !mp_ok[mp])
            wry = 1'b1;
        last_dst = dst;
        i_ydst   <= dst;
        i_ydev   <= dev;
        i_wry    <= wry;
        i_alu_en <= en;
        i_alu_y  <= alu;
        i_dsrc   <= src;
        i_mpadr  <= mp;
        i_iomp   <= r[21];
        i_ffcnt  <= ffcnt_t'(r[20:16]);
        i_ise    <= (r[24:22] == 3'd0);
        i_cond   <= cond_t'(r[30:26]);
        i_icc    <= r[31];
        i_data   <= {next_random(), next_random()};
        if (phase == 5)                                 // Offered idle or busy
            i_arbi <= (r2[1:0] == 2'd3) ? ARB_IDLE : arb_op_t'({2'b00, r2[1:0]});
        else
            i_arbi <= (r2[4:2] == 3'd0) ? ARB_READ : ARB_IDLE;
    endtask

    task automatic check_outputs();
        logic [63:0] exp_ad;
        exp_ad = 64'd0;
        if (m_st == ST_ADDR)
            exp_ad = {32'd0, m_ureg};                   // Address phase
        else if (m_st == ST_DATA && m_req == 4'd2)
            exp_ad = m_wdata;                           // Write data phase
        compare("o_y", model_y(), o_y);
        compare("o_d", model_d(), o_d);
        compare("o_cond", {63'd0, model_cond()}, {63'd0, o_cond});
        compare("o_astb", {63'd0, m_st == ST_ADDR}, {63'd0, o_astb});
        compare("o_rd", {63'd0, m_st == ST_DATA && m_req == 4'd1}, {63'd0, o_rd});
        compare("o_wr", {63'd0, m_st == ST_DATA && m_req == 4'd2}, {63'd0, o_wr});
        compare("o_ad", exp_ad, o_ad);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > TIMEOUT) begin
            $display("Timeout: run went past %0d cycles", TIMEOUT);
            $display("Done: errors found");
            $fatal(1, "Timeout");
        end
    end

    // --------------------
    initial begin
        i_ydst = YD_NONE;
        i_ydev = YV_NONE;
        i_wry = 1'b0;
        i_alu_en = 1'b0;
        i_alu_y = '0;
        i_dsrc = DS_NONE;
        i_mpadr = '0;
        i_iomp = 1'b1;                                  // Flag decoder off
        i_ffcnt = ffcnt_t'(5'd0);
        i_ise = 1'b0;
        i_cond = YES;
        i_icc = 1'b1;
        i_arbi = ARB_IDLE;
        i_data = '0;
        m_modgn = '0;
        m_procn = '0;
        m_physpg = '0;
        m_ureg = '0;
        m_wdata = '0;
        m_rdata = '0;
        m_rr = '0;
        m_tr0 = 1'b0;
        m_tr1 = 1'b0;
        m_tkk = 1'b0;
        m_eml = 1'b0;
        m_req = 4'd0;
        m_st = ST_IDLE;
        last_dst = YD_NONE;
        for (int i = 0; i < (1 << PAGE_BITS); i++)
            ps_ok[i] = 1'b0;
        for (int i = 0; i < (1 << MP_BITS); i++)
            mp_ok[i] = 1'b0;
        @(negedge clk);
        while (reset)
            @(negedge clk);
        for (int p = 1; p <= N_PHASES; p++) begin     // Regs, memories, flags, cond, bus
            for (int n = 0; n < PHASE_LEN; n++) begin
                @(posedge clk);
                advance_model();
                drive_random(p);
                @(negedge clk);
                check_outputs();
            end
        end
        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
hdl/besm_pkg.sv
hdl/flag_unit.sv
hdl/special_regs.sv
hdl/bus_arbiter.sv
hdl/cpu_ctrl.sv
tb/tb_clock.sv
tb/cpu_ctrl_assert.sv
tb/cpu_ctrl_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the testbench with Verilator, then judge the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f compile.f --top-module cpu_ctrl_tb > sim.log 2>&1 \
    && ./obj_dir/Vcpu_ctrl_tb >> sim.log 2>&1 \
    || echo "Build or simulation stopped early" >> sim.log
cat sim.log
grep -q "Done: errors found" sim.log && echo "FAIL" && exit 1
grep -q "Done: no errors" sim.log && echo "PASS" && exit 0
echo "FAIL"
exit 1
